/* verilog.f */
hw/accel_cfg_pkg.sv
hw/lane_mode_pkg.sv
hw/psum_accumulator.sv
hw/sync_fifo.sv
hw/bias_adder.sv
hw/bias_row_top.sv
test/tb_bias_row.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary -f verilog.f --top-module tb_bias_row -Mdir obj_dir -o tb_bias_row
	./obj_dir/tb_bias_row | tee sim.log
	grep -q "Done: no errors" sim.log

clean:
	rm -rf obj_dir sim.log

/* test/tb_bias_row.sv */
module tb_bias_row;
   import accel_cfg_pkg::*;
   import lane_mode_pkg::*;

   localparam int column_num = 4;

   typedef logic [column_num*column_bits-1:0] row_t;

   logic       clk = 1'b0;
   logic       reset = 1'b1;
   lane_mode_t mode = mode_88;
   logic       beat_valid = 1'b0;
   logic       beat_first = 1'b0;
   logic       beat_last = 1'b0;
   row_t       beat_data = '0;
   logic       bias_valid = 1'b0;
   bias_t      bias = '0;
   logic       out_valid;
   row_t       out_row;
   logic       overflow;

   row_t expect_q [$];          // Expected rows in output order
   int   checks = 0;
   int   errors = 0;
   int   test_errors = 0;

   bias_row_top #(.column_num(column_num), .fifo_depth(4)) dut (.*);

   always #2 clk = ~clk;

   //////////////////////////////
   // Reference model
   //////////////////////////////

   // Per-lane sum of beats plus the channel bias, wrapped at the lane width
   function automatic row_t expected_row(input lane_mode_t m, input row_t beats [3],
                                         input int n, input bias_t b);
      row_t                     r;
      logic [lane_width_88-1:0] l88;
      logic [lane_width_18-1:0] l18;
      r = '0;                   // Mode 0 upper bits stay zero
      for (int c = 0; c < column_num; c++) begin
         if (m == mode_88) begin
            for (int k = 0; k < lanes_88; k++) begin
               l88 = lane_width_88'(b[7:0]);
               for (int j = 0; j < n; j++) begin
                  l88 += beats[j][c*column_bits + k*lane_width_88 +: lane_width_88];
               end
               r[c*column_bits + k*lane_width_88 +: lane_width_88] = l88;
            end
         end else begin
            for (int k = 0; k < lanes_18; k++) begin
               l18 = lane_width_18'((k < 2) ? b[7:0] : b[15:8]);   // Channel A, then B
               for (int j = 0; j < n; j++) begin
                  l18 += beats[j][c*column_bits + k*lane_width_18 +: lane_width_18];
               end
               r[c*column_bits + k*lane_width_18 +: lane_width_18] = l18;
            end
         end
      end
      return r;
   endfunction

   //////////////////////////////
   // Compare tasks and checker
   //////////////////////////////

   task automatic check_row(input row_t actual, input row_t expected, input string what);
      checks++;
      if (actual !== expected) begin
         errors++;
         $display("FAIL t=%0t %s: got %h, expected %h", $time, what, actual, expected);
      end
   endtask

   task automatic check_flag(input logic actual, input logic expected, input string what);
      checks++;
      if (actual !== expected) begin
         errors++;
         $display("FAIL t=%0t %s: got %b, expected %b", $time, what, actual, expected);
      end
   endtask

   always @(negedge clk) begin
      if (!reset && out_valid) begin
         if (expect_q.size() == 0) begin
            errors++;
            $display("Result at time %0t arrived with no row pending", $time);
         end else begin
            check_row(out_row, expect_q.pop_front(), "out_row");
         end
      end
   end

   //////////////////////////////
   // Stimulus
   //////////////////////////////

   task automatic apply_reset();
      @(negedge clk);
      reset = 1'b1;
      repeat (4) @(negedge clk);
      reset = 1'b0;
      expect_q.delete();
   endtask

   task automatic drive_beat(input lane_mode_t m, input logic first, input logic last,
                             input row_t data);
      @(negedge clk);
      mode       = m;
      beat_valid = 1'b1;
      beat_first = first;
      beat_last  = last;
      beat_data  = data;
   endtask

   task automatic send_row(input lane_mode_t m, input int n, input bias_t b, input bit keep);
      row_t beats [3];
      for (int j = 0; j < 3; j++) begin
         for (int w = 0; w < $bits(row_t) / 32; w++) begin
            beats[j][w*32 +: 32] = $urandom;
         end
      end
      for (int j = 0; j < n; j++) begin
         drive_beat(m, j == 0, j == n - 1, beats[j]);
      end
      @(negedge clk);           // Idle cycle, mode steady while the row is pushed
      beat_valid = 1'b0;
      beat_first = 1'b0;
      beat_last  = 1'b0;
      if (keep) begin
         expect_q.push_back(expected_row(m, beats, n, b));
      end
   endtask

   task automatic send_bias(input bias_t b);
      @(negedge clk);
      bias_valid = 1'b1;
      bias       = b;
      @(negedge clk);
      bias_valid = 1'b0;
   endtask

   task automatic quiet_cycles(input int n, input string what);
      repeat (n) begin
         @(negedge clk);
         check_flag(out_valid, 1'b0, what);
      end
   endtask

   task automatic wait_results(input int limit);
      int cycles;
      cycles = 0;
      while (expect_q.size() != 0 && cycles < limit) begin
         @(negedge clk);
         cycles++;
      end
      if (expect_q.size() != 0) begin
         errors++;
         $display("Timeout: %0d results still missing after %0d cycles", expect_q.size(), limit);
      end
      repeat (8) @(negedge clk);    // Window for stray extra results
   endtask

   task automatic finish_test(input int num, input string name);
      $display("Test %0d %s: %0d errors", num, name, errors - test_errors);
      test_errors = errors;
   endtask

   initial begin
      bias_t      b [6];
      lane_mode_t m;
      bit         lead;
      void'($urandom(7));

      apply_reset();
      check_flag(out_valid, 1'b0, "out_valid after reset");
      check_flag(overflow, 1'b0, "overflow after reset");
      check_row(out_row, '0, "out_row after reset");
      send_bias(16'h1234);
      send_bias(16'h00ff);
      quiet_cycles(8, "out_valid with biases only");
      finish_test(1, "reset and biases only");

      apply_reset();
      for (int i = 0; i < 4; i++) begin
         b[0] = bias_t'($urandom);
         send_row(mode_88, 1, b[0], 1'b1);
         send_bias(b[0]);
      end
      wait_results(40);
      finish_test(2, "mode 0 single beat");

      apply_reset();
      for (int i = 0; i < 3; i++) begin
         b[0] = bias_t'($urandom);
         send_row(mode_18, 2 + i % 2, b[0], 1'b1);
         send_bias(b[0]);
      end
      // Two beats thrown away by the next first beat
      drive_beat(mode_18, 1'b1, 1'b0, {8{$urandom}});
      drive_beat(mode_18, 1'b0, 1'b0, {8{$urandom}});
      b[0] = bias_t'($urandom);
      send_row(mode_18, 2, b[0], 1'b1);
      send_bias(b[0]);
      wait_results(40);
      finish_test(3, "mode 1 multi beat and restart");

      apply_reset();
      for (int i = 0; i < 3; i++) begin
         b[i] = bias_t'($urandom);
         send_row((i == 1) ? mode_18 : mode_88, i + 1, b[i], 1'b1);
      end
      quiet_cycles(4, "out_valid before any bias");
      for (int i = 0; i < 3; i++) begin
         send_bias(b[i]);
      end
      wait_results(40);
      finish_test(4, "ordering with mode switch");

      apply_reset();
      for (int i = 0; i < 6; i++) begin
         b[i] = bias_t'($urandom);
         send_row(mode_88, 1, b[i], i < 4);    // Rows 5 and 6 find the buffer full
      end
      @(negedge clk);
      check_flag(overflow, 1'b1, "overflow after six rows");
      for (int i = 0; i < 6; i++) begin
         send_bias(b[i]);
      end
      wait_results(40);
      check_flag(overflow, 1'b1, "overflow stays set");
      finish_test(5, "overflow");

      apply_reset();
      for (int i = 0; i < 40; i++) begin
         m    = ($urandom_range(0, 1) == 1) ? mode_18 : mode_88;
         lead = ($urandom_range(0, 1) == 1);
         b[0] = bias_t'($urandom);
         if (lead) begin
            send_bias(b[0]);            // Bias may come ahead of its row
         end
         send_row(m, int'($urandom_range(1, 3)), b[0], 1'b1);
         if (!lead) begin
            send_bias(b[0]);
         end
         repeat ($urandom_range(0, 3)) @(negedge clk);
      end
      wait_results(200);
      check_flag(overflow, 1'b0, "overflow after random rows");
      finish_test(6, "random rows");

      $display("Checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("Done: no errors");
      end else begin
         $display("Done: errors found");
      end
      $finish;
   end

endmodule

/* hw/bias_row_top.sv */
module bias_row_top #(
   parameter int column_num = 4,
   parameter int fifo_depth = 4
) (
   input  logic                                            clk,
   input  logic                                            reset,
   input  lane_mode_pkg::lane_mode_t                       mode,
   input  logic                                            beat_valid,
   input  logic                                            beat_first,
   input  logic                                            beat_last,
   input  logic [column_num*accel_cfg_pkg::column_bits-1:0] beat_data,
   input  logic                                            bias_valid,
   input  accel_cfg_pkg::bias_t                            bias,
   output logic                                            out_valid,
   output logic [column_num*accel_cfg_pkg::column_bits-1:0] out_row,
   output logic                                            overflow
);
   import accel_cfg_pkg::*;

   localparam int row_bits = column_num * column_bits;

   typedef logic [row_bits:0] row_entry_t;      // Mode in the top bit

   logic                row_push;
   logic [row_bits-1:0] row_data;
   row_entry_t          row_head;
   logic                row_empty;
   logic                row_overflow;
   bias_t               bias_head;
   logic                bias_empty;
   logic                bias_overflow;
   logic                pair_pop;

   ////////////////////////////////
   // Producer and buffers
   ////////////////////////////////

   psum_accumulator #(
      .column_num (column_num)
   ) u_psum_accumulator (
      .clk        (clk),
      .reset      (reset),
      .mode       (mode),
      .beat_valid (beat_valid),
      .beat_first (beat_first),
      .beat_last  (beat_last),
      .beat_data  (beat_data),
      .row_push   (row_push),
      .row_data   (row_data)
   );

   // Mode is still the row's own during the push cycle
   sync_fifo #(
      .payload_t  (row_entry_t),
      .fifo_depth (fifo_depth)
   ) u_row_fifo (
      .clk       (clk),
      .reset     (reset),
      .push      (row_push),
      .push_data ({mode, row_data}),
      .pop       (pair_pop),
      .head      (row_head),
      .empty     (row_empty),
      .overflow  (row_overflow)
   );

   sync_fifo #(
      .payload_t  (bias_t),
      .fifo_depth (fifo_depth)
   ) u_bias_fifo (
      .clk       (clk),
      .reset     (reset),
      .push      (bias_valid),
      .push_data (bias),
      .pop       (pair_pop),
      .head      (bias_head),
      .empty     (bias_empty),
      .overflow  (bias_overflow)
   );

   ////////////////////////////////
   // Consumer
   ////////////////////////////////

   bias_adder #(
      .column_num (column_num)
   ) u_bias_adder (
      .clk        (clk),
      .reset      (reset),
      .row_head   (row_head),
      .row_empty  (row_empty),
      .bias_head  (bias_head),
      .bias_empty (bias_empty),
      .pair_pop   (pair_pop),
      .out_valid  (out_valid),
      .out_row    (out_row)
   );

   assign overflow = row_overflow || bias_overflow;     // Either buffer dropped a push

endmodule

/* hw/bias_adder.sv */
module bias_adder #(
   parameter int column_num = 4
) (
   input  logic                                            clk,
   input  logic                                            reset,
   input  logic [column_num*accel_cfg_pkg::column_bits:0]   row_head,
   input  logic                                            row_empty,
   input  accel_cfg_pkg::bias_t                            bias_head,
   input  logic                                            bias_empty,
   output logic                                            pair_pop,
   output logic                                            out_valid,
   output logic [column_num*accel_cfg_pkg::column_bits-1:0] out_row
);
   import accel_cfg_pkg::*;
   import lane_mode_pkg::*;

   localparam int row_bits = column_num * column_bits;

   lane_mode_t             row_mode;
   logic [column_bits-1:0] bias_col;
   logic [row_bits-1:0]    sum_row;

   ////////////////////////////////
   // Pairing
   ////////////////////////////////

   // Row n always meets bias n since both pop together
   assign pair_pop = !row_empty && !bias_empty;

   assign row_mode = lane_mode_t'(row_head[row_bits]);      // Mode stored with the row
   assign bias_col = column_bias(row_mode, bias_head);

   ////////////////////////////////
   // Lane-wise bias add
   ////////////////////////////////

   always_comb begin
      for (int c = 0; c < column_num; c++) begin
         sum_row[c*column_bits +: column_bits] =
            column_lane_add(row_mode, row_head[c*column_bits +: column_bits], bias_col);
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         out_valid <= 1'b0;
         out_row   <= '0;
      end else begin
         out_valid <= pair_pop;
         if (pair_pop) begin
            out_row <= sum_row;     // Holds between results
         end
      end
   end

endmodule

/* hw/sync_fifo.sv */
module sync_fifo #(
   parameter type payload_t  = logic [7:0],
   parameter int  fifo_depth = 4
) (
   input  logic     clk,
   input  logic     reset,
   input  logic     push,
   input  payload_t push_data,
   input  logic     pop,
   output payload_t head,
   output logic     empty,
   output logic     overflow
);

   localparam int ptr_bits = (fifo_depth > 1) ? $clog2(fifo_depth) : 1;
   localparam int cnt_bits = $clog2(fifo_depth + 1);

   payload_t            store [fifo_depth];
   logic [ptr_bits-1:0] rd_ptr;
   logic [ptr_bits-1:0] wr_ptr;
   logic [cnt_bits-1:0] count;
   logic                full;
   logic                do_push;
   logic                do_pop;

   assign full    = (count == cnt_bits'(fifo_depth));
   assign empty   = (count == '0);
   assign do_pop  = pop && !empty;
   assign do_push = push && (!full || do_pop);      // Pop frees a slot this cycle
   assign head    = store[rd_ptr];                  // Show-ahead

   always_ff @(posedge clk) begin
      if (do_push) begin
         store[wr_ptr] <= push_data;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         rd_ptr   <= '0;
         wr_ptr   <= '0;
         count    <= '0;
         overflow <= 1'b0;
      end else begin
         if (do_push) begin
            wr_ptr <= (wr_ptr == ptr_bits'(fifo_depth - 1)) ? '0 : wr_ptr + 1'b1;
         end
         if (do_pop) begin
            rd_ptr <= (rd_ptr == ptr_bits'(fifo_depth - 1)) ? '0 : rd_ptr + 1'b1;
         end
         if (do_push && !do_pop) begin
            count <= count + 1'b1;
         end else if (!do_push && do_pop) begin
            count <= count - 1'b1;
         end
         if (push && !do_push) begin
            overflow <= 1'b1;                       // Sticky until reset
         end
      end
   end

endmodule

/* hw/psum_accumulator.sv */
module psum_accumulator #(
   parameter int column_num = 4
) (
   input  logic                                            clk,
   input  logic                                            reset,
   input  lane_mode_pkg::lane_mode_t                       mode,
   input  logic                                            beat_valid,
   input  logic                                            beat_first,
   input  logic                                            beat_last,
   input  logic [column_num*accel_cfg_pkg::column_bits-1:0] beat_data,
   output logic                                            row_push,
   output logic [column_num*accel_cfg_pkg::column_bits-1:0] row_data
);
   import accel_cfg_pkg::*;
   import lane_mode_pkg::*;

   localparam int row_bits = column_num * column_bits;

   logic [row_bits-1:0] acc;
   logic [row_bits-1:0] acc_next;

   ////////////////////////////////
   // Next accumulator value
   ////////////////////////////////

   always_comb begin
      for (int c = 0; c < column_num; c++) begin
         if (beat_first) begin
            // Adding zero masks the slice to the mode's lanes
            acc_next[c*column_bits +: column_bits] =
               column_lane_add(mode, '0, beat_data[c*column_bits +: column_bits]);
         end else begin
            acc_next[c*column_bits +: column_bits] =
               column_lane_add(mode, acc[c*column_bits +: column_bits],
                               beat_data[c*column_bits +: column_bits]);
         end
      end
   end

   ////////////////////////////////
   // Registers
   ////////////////////////////////

   always_ff @(posedge clk) begin
      if (beat_valid) begin
         acc <= acc_next;
      end
   end

   // Completed sum sits in acc during the push cycle
   always_ff @(posedge clk) begin
      if (reset) begin
         row_push <= 1'b0;
      end else begin
         row_push <= beat_valid && beat_last;
      end
   end

   assign row_data = acc;       // Held until the next beat arrives

endmodule

/* hw/lane_mode_pkg.sv */
package lane_mode_pkg;
   import accel_cfg_pkg::*;

   typedef enum logic {
      mode_88 = 1'b0,       // 8x8 precision
      mode_18 = 1'b1        // 1x8 precision, two channels
   } lane_mode_t;

   ////////////////////////////////
   // Lane-wise column add
   ////////////////////////////////

   // Each lane wraps at its own width, mode 0 keeps the top bits clear
   function automatic logic [column_bits-1:0] column_lane_add(
      input lane_mode_t             mode,
      input logic [column_bits-1:0] a,
      input logic [column_bits-1:0] b
   );
      logic [column_bits-1:0] sum;
      sum = '0;
      if (mode == mode_88) begin
         for (int i = 0; i < lanes_88; i++) begin
            sum[i*lane_width_88 +: lane_width_88] =
               a[i*lane_width_88 +: lane_width_88] + b[i*lane_width_88 +: lane_width_88];
         end
      end else begin
         for (int i = 0; i < lanes_18; i++) begin
            sum[i*lane_width_18 +: lane_width_18] =
               a[i*lane_width_18 +: lane_width_18] + b[i*lane_width_18 +: lane_width_18];
         end
      end
      return sum;
   endfunction

   ////////////////////////////////
   // Bias expansion
   ////////////////////////////////

   function automatic logic [column_bits-1:0] column_bias(
      input lane_mode_t mode,
      input bias_t      bias
   );
      logic [column_bits-1:0] operand;
      operand = '0;                         // Zero extension comes from here
      if (mode == mode_88) begin
         for (int i = 0; i < lanes_88; i++) begin
            operand[i*lane_width_88 +: bias_byte_bits] = bias[bias_byte_bits-1:0];
         end
      end else begin
         for (int i = 0; i < lanes_18; i++) begin
            if (i < lanes_18 / 2) begin
               operand[i*lane_width_18 +: bias_byte_bits] = bias[bias_byte_bits-1:0];
            end else begin
               operand[i*lane_width_18 +: bias_byte_bits] = bias[2*bias_byte_bits-1:bias_byte_bits];
            end
         end
      end
      return operand;
   endfunction

endpackage

/* hw/accel_cfg_pkg.sv */
package accel_cfg_pkg;

   ////////////////////////////////
   // Lane geometry
   ////////////////////////////////

   localparam int headroom_bits = 8;        // Growth room for accumulation

   // 16-bit products plus headroom
   localparam int lane_width_88 = 16 + headroom_bits;
   // 8-bit products plus headroom
   localparam int lane_width_18 = 8 + headroom_bits;

   localparam int lanes_88 = 2;             // One channel, two pixels
   localparam int lanes_18 = 4;             // Two channels, two pixels each

   // Column slice, sized for the wider of the two layouts
   localparam int column_bits = lane_width_18 * lanes_18;

   ////////////////////////////////
   // Bias word
   ////////////////////////////////

   localparam int bias_byte_bits = 8;       // One bias per output channel

   // Low byte is mode 0 bias and channel A in mode 1
   // High byte is channel B in mode 1
   typedef logic [2*bias_byte_bits-1:0] bias_t;

endpackage
